/* arp_defs.svh */
//**********************************************************
// widths and constants of the 64-bit ARP transmit path
// only a 64-bit datapath with 8 byte lanes is supported
//**********************************************************
`ifndef ARP_DEFS_SVH
`define ARP_DEFS_SVH

// payload datapath
`define ARP_DATA_W 64
`define ARP_KEEP_W 8

// ARP address lengths for Ethernet/IPv4
`define ARP_HLEN 6
`define ARP_PLEN 4

// the 28-byte ARP body takes four 64-bit beats
`define ARP_BEATS 4

// only the low four lanes of the final beat carry data
`define ARP_LAST_KEEP 8'h0f

`endif

/* arp_frame_serializer.sv */
//**********************************************************
// serializes one ARP frame into four 64-bit payload beats
// beat_ready must follow the early-ready output register
//**********************************************************
`timescale 1ns/100ps

`include "arp_defs.svh"

module arp_frame_serializer (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_valid,
    input  arp_pkg::arp_frame_t frame,
    output logic                frame_ready,
    output logic                hdr_valid,
    output eth_pkg::eth_hdr_t   hdr,
    input  logic                hdr_ready,
    output logic                beat_valid,
    output eth_pkg::eth_beat_t  beat,
    input  logic                beat_ready,
    output logic                busy
);
    import arp_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    // byte offset of the final beat
    localparam logic [7:0] LAST_PTR = 8'((`ARP_BEATS - 1) * 8);

    state_t      state_q;
    state_t      state_d;
    logic [7:0]  ptr_q;
    logic [7:0]  ptr_d;
    logic        frame_ready_d;
    logic        hdr_valid_d;
    logic        store_frame;
    arp_fields_t arp_q;

    // big-endian word to lanes with the most significant byte in lane 0
    function automatic logic [`ARP_DATA_W-1:0] to_lanes(
        input logic [`ARP_DATA_W-1:0] word
    );
        logic [`ARP_DATA_W-1:0] lanes;
        for (int i = 0; i < `ARP_KEEP_W; i++) begin
            lanes[8*i +: 8] = word[`ARP_DATA_W-8-8*i +: 8];
        end
        return lanes;
    endfunction

    // htype, ptype, hlen, plen, oper
    function automatic logic [`ARP_DATA_W-1:0] first_word(input arp_fields_t f);
        return {f.htype, f.ptype, 8'(`ARP_HLEN), 8'(`ARP_PLEN), f.oper};
    endfunction

    always_comb begin
        state_d       = state_q;
        ptr_d         = ptr_q;
        frame_ready_d = 1'b0;
        store_frame   = 1'b0;
        hdr_valid_d   = hdr_valid & ~hdr_ready;

        beat_valid = 1'b0;
        beat       = '0;

        case (state_q)
            ST_IDLE: begin
                ptr_d = '0;
                // hold off a new frame until the header has left
                frame_ready_d = ~hdr_valid;

                if (frame_valid && frame_ready) begin
                    store_frame   = 1'b1;
                    frame_ready_d = 1'b0;
                    hdr_valid_d   = 1'b1;
                    state_d       = ST_WRITE;

                    // first beat taken straight from the input to save a cycle
                    if (beat_ready) begin
                        beat_valid = 1'b1;
                        beat.tdata = to_lanes(first_word(frame.arp));
                        beat.tkeep = '1;
                        ptr_d      = 8'd8;
                    end
                end
            end

            ST_WRITE: begin
                if (beat_ready) begin
                    beat_valid = 1'b1;
                    beat.tkeep = '1;
                    ptr_d      = ptr_q + 8'd8;

                    case (ptr_q)
                        8'h00: beat.tdata = to_lanes(first_word(arp_q));
                        8'h08: beat.tdata = to_lanes({arp_q.sha, arp_q.spa[31:16]});
                        8'h10: beat.tdata = to_lanes({arp_q.spa[15:0], arp_q.tha});
                        LAST_PTR: begin
                            // tpa then zero padding in the upper lanes
                            beat.tdata    = to_lanes({arp_q.tpa, 32'h0});
                            beat.tkeep    = `ARP_LAST_KEEP;
                            beat.tlast    = 1'b1;
                            frame_ready_d = ~hdr_valid;
                            state_d       = ST_IDLE;
                        end
                        default: beat.tdata = '0;
                    endcase
                end
            end

            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            ptr_q       <= '0;
            frame_ready <= 1'b0;
            hdr_valid   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state_q     <= state_d;
            ptr_q       <= ptr_d;
            frame_ready <= frame_ready_d;
            hdr_valid   <= hdr_valid_d;
            busy        <= state_d != ST_IDLE;
        end
    end

    // frame fields
    always_ff @(posedge clk) begin
        if (store_frame) begin
            hdr   <= frame.eth;
            arp_q <= frame.arp;
        end
    end

endmodule

/* arp_pkg.sv */
//**********************************************************
// ARP-side types, for Ethernet hardware and IPv4 addresses
//**********************************************************
package arp_pkg;

    // ARP body fields, all in network order
    typedef struct packed {
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [15:0] oper;
        logic [47:0] sha;
        logic [31:0] spa;
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_fields_t;

    // inbound frame, Ethernet header plus ARP fields in parallel
    typedef struct packed {
        eth_pkg::eth_hdr_t eth;
        arp_fields_t       arp;
    } arp_frame_t;

endpackage

/* arp_tx_top.f */
+incdir+.
eth_pkg.sv
arp_pkg.sv
arp_frame_serializer.sv
eth_payload_out_reg.sv
arp_tx_top.sv
arp_tx_top_tb.sv

/* arp_tx_top.sv */
//**********************************************************
// ARP transmit path, 64-bit payload with separate header port
// tuser is always low, frames are never aborted
//**********************************************************
`timescale 1ns/100ps

module arp_tx_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_valid,
    input  arp_pkg::arp_frame_t frame,
    output logic                frame_ready,
    output logic                hdr_valid,
    output eth_pkg::eth_hdr_t   hdr,
    input  logic                hdr_ready,
    output logic                payload_valid,
    output eth_pkg::eth_beat_t  payload,
    input  logic                payload_ready,
    output logic                busy
);
    import eth_pkg::*;

    // serializer to output register
    logic      beat_valid;
    eth_beat_t beat;
    logic      beat_ready;

    arp_frame_serializer arp_frame_serializer_i (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_ready (frame_ready),
        .hdr_valid   (hdr_valid),
        .hdr         (hdr),
        .hdr_ready   (hdr_ready),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .beat_ready  (beat_ready),
        .busy        (busy)
    );

    eth_payload_out_reg eth_payload_out_reg_i (
        .clk           (clk),
        .rst           (rst),
        .beat_valid    (beat_valid),
        .beat          (beat),
        .beat_ready    (beat_ready),
        .payload_valid (payload_valid),
        .payload       (payload),
        .payload_ready (payload_ready)
    );

endmodule

/* arp_tx_top_tb.sv */
//**********************************************************
// testbench for arp_tx_top with random frames and ready patterns
// all checks are concurrent assertions on the rising clock edge
//**********************************************************
`timescale 1ns/100ps

`include "arp_defs.svh"

module arp_tx_top_tb;
    import eth_pkg::*;
    import arp_pkg::*;

    localparam int N_RAND     = 24;
    localparam int N_HOLD     = 12;
    localparam int N_FRAMES   = N_RAND + N_HOLD;
    // 40 cycles of 40 ns per frame plus reset and drain margin
    localparam int TIMEOUT_NS = N_FRAMES * 40 * 40 + 4000;

    logic       clk = 1'b0;
    logic       rst;
    logic       frame_valid;
    arp_frame_t frame;
    logic       frame_ready;
    logic       hdr_valid;
    eth_hdr_t   hdr;
    logic       hdr_ready;
    logic       payload_valid;
    eth_beat_t  payload;
    logic       payload_ready;
    logic       busy;

    // scoreboard queues with registered fronts for the assertions
    eth_hdr_t  hdr_q[$];
    eth_beat_t beat_q[$];
    eth_hdr_t  exp_hdr;
    eth_beat_t exp_beat;
    int        exp_hdr_cnt;
    int        exp_beat_cnt;
    int        pending;

    // previous-cycle copies
    eth_hdr_t  hdr_prev;
    eth_beat_t payload_prev;
    logic      hdr_stall_prev;
    logic      payload_stall_prev;
    logic      rst_prev;

    logic        ready_hold;
    logic        done;
    int          errors;
    logic [31:0] rng_frame;
    logic [31:0] rng_ready;

    arp_tx_top arp_tx_top_i (
        .clk           (clk),
        .rst           (rst),
        .frame_valid   (frame_valid),
        .frame         (frame),
        .frame_ready   (frame_ready),
        .hdr_valid     (hdr_valid),
        .hdr           (hdr),
        .hdr_ready     (hdr_ready),
        .payload_valid (payload_valid),
        .payload       (payload),
        .payload_ready (payload_ready),
        .busy          (busy)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic show_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        errors++;
        $display("mismatch %s: got %0h expected %0h", name, got, exp);
    endtask

    task automatic show_failure(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    // reference beats from the ARP body bytes in wire order with byte 0 in lane 0
    task automatic push_expected(input arp_frame_t f);
        logic [255:0] body;
        eth_beat_t    b;
        body = {f.arp.htype, f.arp.ptype, 8'h06, 8'h04, f.arp.oper,
                f.arp.sha, f.arp.spa, f.arp.tha, f.arp.tpa, 32'h0};
        hdr_q.push_back(f.eth);
        for (int n = 0; n < 4; n++) begin
            for (int i = 0; i < 8; i++) begin
                b.tdata[8*i +: 8] = body[255 - 8*(8*n + i) -: 8];
            end
            b.tkeep = (n == 3) ? `ARP_LAST_KEEP : 8'hff;
            b.tlast = (n == 3);
            b.tuser = 1'b0;
            beat_q.push_back(b);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            hdr_q.delete();
            beat_q.delete();
            pending <= 0;
        end else begin
            if (hdr_valid && hdr_ready && hdr_q.size() != 0) begin
                void'(hdr_q.pop_front());
            end
            if (payload_valid && payload_ready && beat_q.size() != 0) begin
                void'(beat_q.pop_front());
            end
            if (frame_valid && frame_ready) begin
                push_expected(frame);
            end
            pending <= pending + int'(frame_valid && frame_ready)
                     - int'(payload_valid && payload_ready && payload.tlast);
        end
        exp_hdr_cnt        <= hdr_q.size();
        exp_beat_cnt       <= beat_q.size();
        exp_hdr            <= (hdr_q.size() != 0) ? hdr_q[0] : '0;
        exp_beat           <= (beat_q.size() != 0) ? beat_q[0] : '0;
        hdr_prev           <= hdr;
        payload_prev       <= payload;
        hdr_stall_prev     <= hdr_valid && !hdr_ready;
        payload_stall_prev <= payload_valid && !payload_ready;
        rst_prev           <= rst;
    end

    hdr_check : assert property (
        @(posedge clk) disable iff (rst)
        (hdr_valid && hdr_ready) |-> (exp_hdr_cnt != 0 && hdr == exp_hdr)
    ) else begin
        if ($sampled(exp_hdr_cnt) == 0) begin
            show_failure("a header was sent with no frame outstanding");
        end else begin
            show_mismatch("hdr", {16'h0, $sampled(hdr)}, {16'h0, $sampled(exp_hdr)});
        end
    end

    beat_check : assert property (
        @(posedge clk) disable iff (rst)
        (payload_valid && payload_ready) |-> (exp_beat_cnt != 0 && payload == exp_beat)
    ) else begin
        if ($sampled(exp_beat_cnt) == 0) begin
            show_failure("a payload beat was sent with no beat outstanding");
        end else begin
            show_mismatch("payload", {54'h0, $sampled(payload)},
                          {54'h0, $sampled(exp_beat)});
        end
    end

    tuser_check : assert property (
        @(posedge clk) disable iff (rst) payload_valid |-> !payload.tuser
    ) else show_mismatch("payload.tuser", 128'($sampled(payload.tuser)), 128'h0);

    payload_hold : assert property (
        @(posedge clk) disable iff (rst)
        payload_stall_prev |-> (payload_valid && payload == payload_prev)
    ) else begin
        if (!$sampled(payload_valid)) begin
            show_failure("payload_valid dropped before the beat was accepted");
        end else begin
            show_mismatch("payload", {54'h0, $sampled(payload)},
                          {54'h0, $sampled(payload_prev)});
        end
    end

    hdr_hold : assert property (
        @(posedge clk) disable iff (rst)
        hdr_stall_prev |-> (hdr_valid && hdr == hdr_prev)
    ) else begin
        if (!$sampled(hdr_valid)) begin
            show_failure("hdr_valid dropped before the header was accepted");
        end else begin
            show_mismatch("hdr", {16'h0, $sampled(hdr)}, {16'h0, $sampled(hdr_prev)});
        end
    end

    ready_vs_hdr : assert property (
        @(posedge clk) disable iff (rst) !(frame_ready && hdr_valid)
    ) else show_failure("frame_ready was high while hdr_valid was high");

    ready_vs_busy : assert property (
        @(posedge clk) disable iff (rst) !(frame_ready && busy)
    ) else show_failure("frame_ready and busy were high together");

    // busy falls once beat 3 is written while beat 3 is still on the output
    busy_check : assert property (
        @(posedge clk) disable iff (rst)
        (ready_hold && pending != 0 && !(payload_valid && payload.tlast)) |-> busy
    ) else show_failure("busy was low while a frame was in progress");

    reset_check : assert property (
        @(posedge clk) (rst || rst_prev) |-> (!hdr_valid && !payload_valid && !busy)
    ) else show_failure("an output was active during or just after reset");

    drain_check : assert property (
        @(posedge clk) done |-> (exp_hdr_cnt == 0 && exp_beat_cnt == 0)
    ) else show_failure("headers or beats were still outstanding at the end");

    task automatic random_frame(output arp_frame_t f);
        for (int i = 0; i < 10; i++) begin
            rng_frame = xorshift_next(rng_frame);
            f[32*i +: 32] = rng_frame;
        end
        f.eth.eth_type = 16'h0806;
        f.arp.htype    = 16'h0001;
        f.arp.ptype    = 16'h0800;
        f.arp.oper     = rng_frame[0] ? 16'h0002 : 16'h0001;
    endtask

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic send_frame();
        arp_frame_t f;
        random_frame(f);
        frame       = f;
        frame_valid = 1'b1;
        while (!frame_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        frame_valid = 1'b0;
    endtask

    // DUT idle with no header or beat left on its ports
    task automatic wait_drain();
        while (!frame_ready || hdr_valid || payload_valid || busy) begin
            @(negedge clk);
        end
    endtask

    // random ready patterns with header stretches of about eight cycles
    initial begin
        payload_ready = 1'b0;
        hdr_ready     = 1'b0;
        rng_ready     = 32'he09d;
        forever begin
            @(negedge clk);
            rng_ready     = xorshift_next(rng_ready);
            payload_ready = ready_hold | rng_ready[0];
            if (rng_ready[10:8] == 3'd0) begin
                hdr_ready = ~hdr_ready;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("error: the run did not finish within the time limit");
        $display("errors: %0d", errors);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        frame_valid = 1'b0;
        frame       = '0;
        ready_hold  = 1'b0;
        done        = 1'b0;
        errors      = 0;
        rng_frame   = 32'he09d;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // random payload and header back-pressure
        for (int n = 0; n < N_RAND; n++) begin
            send_frame();
            repeat (rng_frame[1:0]) @(negedge clk);
        end
        wait_drain();

        // payload_ready held high for the busy check
        @(posedge clk);
        ready_hold = 1'b1;
        @(negedge clk);
        for (int n = 0; n < N_HOLD; n++) begin
            send_frame();
        end
        wait_drain();

        done = 1'b1;
        repeat (3) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* eth_payload_out_reg.sv */
//**********************************************************
// two-entry payload register with registered early ready
// the source must write only while beat_ready is high
//**********************************************************
`timescale 1ns/100ps

module eth_payload_out_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               beat_valid,
    input  eth_pkg::eth_beat_t beat,
    output logic               beat_ready,
    output logic               payload_valid,
    output eth_pkg::eth_beat_t payload,
    input  logic               payload_ready
);
    import eth_pkg::*;

    logic      temp_valid;
    eth_beat_t temp;
    logic      ready_early;
    logic      load_out;

    // ready next cycle if the sink takes a beat, both entries are empty,
    // or the temp entry is empty and will not be filled this cycle
    assign ready_early = payload_ready
                       | (~temp_valid & ~payload_valid)
                       | (~temp_valid & ~beat_valid);

    // incoming beat goes straight out when the output slot frees up
    assign load_out = payload_ready | ~payload_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_ready    <= 1'b0;
            payload_valid <= 1'b0;
            temp_valid    <= 1'b0;
        end else begin
            beat_ready <= ready_early;

            if (beat_ready) begin
                if (load_out) begin
                    payload_valid <= beat_valid;
                end else begin
                    temp_valid <= beat_valid;
                end
            end else if (payload_ready) begin
                // drain temp into the output slot
                payload_valid <= temp_valid;
                temp_valid    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ready) begin
            if (load_out) begin
                payload <= beat;
            end else begin
                temp <= beat;
            end
        end else if (payload_ready) begin
            payload <= temp;
        end
    end

endmodule

/* eth_pkg.sv */
//**********************************************************
// Ethernet-side types of the ARP transmit path
// payload beat follows the 64-bit datapath in arp_defs.svh
//**********************************************************
`include "arp_defs.svh"

package eth_pkg;

    // Ethernet header, presented beside the payload stream
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one payload beat; valid travels beside it
    // first byte of the frame sits in lane 0
    typedef struct packed {
        logic [`ARP_DATA_W-1:0] tdata;
        logic [`ARP_KEEP_W-1:0] tkeep;
        logic                   tlast;
        logic                   tuser;
    } eth_beat_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# builds arp_tx_top_tb with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=arp_tx_top_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module arp_tx_top_tb \
    -f arp_tx_top.f \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

grep -q "^TESTS PASSED$" "$LOG_FILE"
if [ $? -ne 0 ]; then
    echo "pass message not found in $LOG_FILE"
    exit 1
fi

exit 0
